//--- hw/rvmem_config.svh
// bus width macros for the cpu to sdram bridge
// halfword address split of the cpu byte address

`ifndef rvmem_config_svh
`define rvmem_config_svh

//////////////////////////////
// cpu side
//////////////////////////////
`define rv_addr_width   23
`define rv_data_width   32
`define rv_strb_width   4

//////////////////////////////
// memory side
//////////////////////////////
`define mem_data_width  16
`define mem_addr_width  20          // word address plus halfword select

// word address bits taken from the byte address
`define rv_word_msb     20
`define rv_word_lsb     2

`endif

//--- hw/rvmem_pkg.sv
// shared types of the bridge
// sequencer state encoding and memory opcode

package rvmem_pkg;

    //////////////////////////////
    // sequencer states
    //////////////////////////////
    // seq_wait_low  lower halfword outstanding
    // seq_wait_high upper halfword outstanding
    typedef enum logic [1:0] {
        seq_idle      = 2'd0,
        seq_wait_low  = 2'd1,
        seq_wait_high = 2'd2
    } seq_state_e;

    //////////////////////////////
    // memory opcode
    //////////////////////////////
    // a cpu access with any strobe set is a write
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

endpackage

//--- hw/bridge_req_if.sv
// captured cpu access, handed from capture stage to sequencer

`timescale 1ns/1ns

`include "rvmem_config.svh"

interface bridge_req_if;
    import rvmem_pkg::*;

    logic                      pending;    // access waiting for the sequencer
    mem_op_e                   op;
    logic [`rv_addr_width-1:0] addr;
    logic [`rv_data_width-1:0] wdata;
    logic [`rv_strb_width-1:0] wstrb;
    logic                      take;       // one cycle, clears pending

    modport capture (
        output pending, op, addr, wdata, wstrb,
        input  take
    );

    modport sequencer (
        input  pending, op, addr, wdata, wstrb,
        output take
    );

endinterface

//--- hw/half_done_if.sv
// finished halfword report, sequencer to read assembler

`timescale 1ns/1ns

`include "rvmem_config.svh"

interface half_done_if;
    import rvmem_pkg::*;

    logic    done;      // one cycle pulse per finished halfword
    logic    word;      // 0 lower, 1 upper
    mem_op_e op;
    logic    last;      // final halfword of the access

    modport sequencer (
        output done, word, op, last
    );

    modport assembler (
        input  done, word, op, last
    );

endinterface

//--- hw/request_capture.sv
// cpu access capture stage
// finds the rising edge of rv_valid and holds the access as pending

`timescale 1ns/1ns

`include "rvmem_config.svh"

module request_capture (
    input  logic                      clk,
    input  logic                      sys_resetn,
    input  logic                      rv_valid,
    input  logic [`rv_addr_width-1:0] rv_addr,
    input  logic [`rv_data_width-1:0] rv_wdata,
    input  logic [`rv_strb_width-1:0] rv_wstrb,
    bridge_req_if.capture             req
);
    import rvmem_pkg::*;

    logic valid_q;      // rv_valid one cycle ago
    logic valid_rise;

    assign valid_rise = rv_valid & ~valid_q;

    //////////////////////////////
    // control
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            valid_q     <= 1'b0;
            req.pending <= 1'b0;
        end else begin
            valid_q <= rv_valid;
            // a new edge wins, so nothing gets dropped
            if (valid_rise) begin
                req.pending <= 1'b1;
            end else if (req.take) begin
                req.pending <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // access payload
    //////////////////////////////
    // cpu holds everything until rv_ready, one copy is enough
    always_ff @(posedge clk) begin
        if (valid_rise) begin
            req.addr  <= rv_addr;
            req.wdata <= rv_wdata;
            req.wstrb <= rv_wstrb;
            req.op    <= (|rv_wstrb) ? op_write : op_read;
        end
    end

endmodule

//--- hw/halfword_sequencer.sv
// halfword sequencer
// splits one cpu access into toggle requests on the memory port
// skips the halfword of a write that has no strobes in it

`timescale 1ns/1ns

`include "rvmem_config.svh"

module halfword_sequencer (
    input  logic                         clk,
    input  logic                         sys_resetn,
    input  logic                         mem_ack,
    output logic                         mem_req,
    output logic [`mem_addr_width-1:0]   mem_addr,
    output logic [`mem_data_width-1:0]   mem_din,
    output logic [`mem_data_width/8-1:0] mem_ds,
    output logic                         mem_we,
    bridge_req_if.sequencer              req,
    half_done_if.sequencer               done_bus
);
    import rvmem_pkg::*;

    seq_state_e state;

    logic                         is_write;
    logic                         lower_empty;   // write without lower strobes
    logic                         need_upper;
    logic                         ack_match;
    logic [`mem_addr_width-2:0]   word_addr;
    logic [`mem_data_width/8-1:0] lo_ds;
    logic [`mem_data_width/8-1:0] hi_ds;

    logic issue;        // toggle mem_req at this edge
    logic issue_hi;     // the issued request is the upper halfword
    logic fin;          // outstanding halfword acked
    logic fin_word;
    logic fin_last;

    assign is_write    = (req.op == op_write);
    assign lower_empty = is_write && (req.wstrb[1:0] == 2'b00);
    assign need_upper  = !(is_write && (req.wstrb[3:2] == 2'b00));
    assign ack_match   = (mem_ack == mem_req);
    assign word_addr   = req.addr[`rv_word_msb:`rv_word_lsb];

    // reads always take both bytes
    assign lo_ds = is_write ? req.wstrb[1:0] : 2'b11;
    assign hi_ds = is_write ? req.wstrb[3:2] : 2'b11;

    assign req.take = (state == seq_idle) && req.pending;

    //////////////////////////////
    // request decode
    //////////////////////////////
    always_comb begin
        issue    = 1'b0;
        issue_hi = 1'b0;
        case (state)
            seq_idle: begin
                if (req.pending) begin
                    issue    = 1'b1;
                    issue_hi = lower_empty;     // upper only shortcut
                end
            end
            seq_wait_low: begin
                if (ack_match && need_upper) begin
                    issue    = 1'b1;
                    issue_hi = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign fin      = ack_match && (state != seq_idle);
    assign fin_word = (state == seq_wait_high);
    assign fin_last = fin_word || !need_upper;  // lower only shortcut ends here

    //////////////////////////////
    // state and handshake
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state         <= seq_idle;
            mem_req       <= 1'b0;
            done_bus.done <= 1'b0;
        end else begin
            done_bus.done <= fin;
            if (issue) begin
                mem_req <= ~mem_req;
            end
            case (state)
                seq_idle: begin
                    if (req.pending) begin
                        state <= issue_hi ? seq_wait_high : seq_wait_low;
                    end
                end
                seq_wait_low: begin
                    if (ack_match) begin
                        state <= need_upper ? seq_wait_high : seq_idle;
                    end
                end
                seq_wait_high: begin
                    if (ack_match) begin
                        state <= seq_idle;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    //////////////////////////////
    // memory request payload
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (issue) begin
            mem_addr <= {word_addr, issue_hi};
            mem_din  <= issue_hi ? req.wdata[31:16] : req.wdata[15:0];
            mem_ds   <= issue_hi ? hi_ds : lo_ds;
            mem_we   <= is_write;
        end
        if (fin) begin
            done_bus.word <= fin_word;
            done_bus.last <= fin_last;
            done_bus.op   <= req.op;
        end
    end

endmodule

//--- hw/read_assembler.sv
// read data assembly and cpu ready pulse

`timescale 1ns/1ns

`include "rvmem_config.svh"

module read_assembler (
    input  logic                       clk,
    input  logic                       sys_resetn,
    input  logic [`mem_data_width-1:0] mem_dout,
    half_done_if.assembler             done_bus,
    output logic                       rv_ready,
    output logic [`rv_data_width-1:0]  rv_rdata
);
    import rvmem_pkg::*;

    logic rd_done;      // finished read halfword

    assign rd_done = done_bus.done && (done_bus.op == op_read);

    // one pulse per access, a cycle after the final halfword
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            rv_ready <= 1'b0;
        end else begin
            rv_ready <= done_bus.done && done_bus.last;
        end
    end

    //////////////////////////////
    // halfword merge
    //////////////////////////////
    // mem_dout still holds the acked halfword while done is high
    always_ff @(posedge clk) begin
        if (rd_done) begin
            if (done_bus.word) begin
                rv_rdata[`rv_data_width-1:`mem_data_width] <= mem_dout;
            end else begin
                rv_rdata[`mem_data_width-1:0] <= mem_dout;
            end
        end
    end

endmodule

//--- hw/rvmem_bridge.sv
// cpu to sdram bus bridge, top level
// capture stage, halfword sequencer and read assembler

`timescale 1ns/1ns

`include "rvmem_config.svh"

module rvmem_bridge (
    input  logic                         clk,
    input  logic                         sys_resetn,

    // cpu side, picorv32 style
    input  logic                         rv_valid,
    input  logic [`rv_addr_width-1:0]    rv_addr,
    input  logic [`rv_data_width-1:0]    rv_wdata,
    input  logic [`rv_strb_width-1:0]    rv_wstrb,
    output logic                         rv_ready,
    output logic [`rv_data_width-1:0]    rv_rdata,

    // memory side, toggle req/ack
    output logic                         mem_req,
    input  logic                         mem_ack,
    output logic [`mem_addr_width-1:0]   mem_addr,
    output logic [`mem_data_width-1:0]   mem_din,
    output logic [`mem_data_width/8-1:0] mem_ds,
    output logic                         mem_we,
    input  logic [`mem_data_width-1:0]   mem_dout
);

    bridge_req_if req_bus ();
    half_done_if  done_bus ();

    //////////////////////////////
    // stages
    //////////////////////////////
    request_capture u_capture (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .rv_valid   (rv_valid),
        .rv_addr    (rv_addr),
        .rv_wdata   (rv_wdata),
        .rv_wstrb   (rv_wstrb),
        .req        (req_bus)
    );

    halfword_sequencer u_sequencer (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .mem_ack    (mem_ack),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_din    (mem_din),
        .mem_ds     (mem_ds),
        .mem_we     (mem_we),
        .req        (req_bus),
        .done_bus   (done_bus)
    );

    read_assembler u_assembler (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .mem_dout   (mem_dout),
        .done_bus   (done_bus),
        .rv_ready   (rv_ready),
        .rv_rdata   (rv_rdata)
    );

endmodule

//--- dv/tb_clock_gen.sv
// testbench clock and reset source
// free running clock, reset held low for a few rising edges

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic sys_resetn
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        sys_resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        sys_resetn = 1'b1;      // released just after an edge
    end

endmodule

//--- dv/mem_responder.sv
// halfword memory model standing in for the sdram controller
// answers toggle requests after a random number of cycles
// counts the requests it served

`timescale 1ns/1ns

`include "rvmem_config.svh"

module mem_responder #(
    parameter logic [31:0] latency_seed = 32'h8d45_f496
) (
    input  logic                         clk,
    input  logic                         sys_resetn,
    input  logic                         mem_req,
    input  logic [`mem_addr_width-1:0]   mem_addr,
    input  logic [`mem_data_width-1:0]   mem_din,
    input  logic [`mem_data_width/8-1:0] mem_ds,
    input  logic                         mem_we,
    output logic                         mem_ack,
    output logic [`mem_data_width-1:0]   mem_dout,
    output int                           req_count
);

    logic [`mem_data_width-1:0] mem [0:(1 << `mem_addr_width)-1];

    integer seed;
    int     delay;

    // every address bit shows up in the pattern
    function automatic logic [15:0] fill_half(input logic [`mem_addr_width-1:0] a);
        return a[15:0] ^ {a[19:16], 12'h5a3};
    endfunction

    task automatic serve_request();
        if (mem_we) begin
            if (mem_ds[1]) begin
                mem[mem_addr][15:8] = mem_din[15:8];
            end
            if (mem_ds[0]) begin
                mem[mem_addr][7:0] = mem_din[7:0];
            end
        end else begin
            mem_dout = mem[mem_addr];
        end
        mem_ack   = mem_req;      // completes the toggle
        req_count = req_count + 1;
    endtask

    initial begin
        seed      = latency_seed;
        mem_ack   = 1'b0;
        mem_dout  = '0;
        req_count = 0;
        for (int i = 0; i < (1 << `mem_addr_width); i++) begin
            mem[i] = fill_half(i[`mem_addr_width-1:0]);
        end
    end

    //////////////////////////////
    // request handling
    //////////////////////////////
    // a toggle seen at negedge is answered 1 to 8 cycles later
    always begin
        @(negedge clk);
        if (sys_resetn && (mem_req != mem_ack)) begin
            delay = $random(seed) & 32'h7;
            repeat (delay + 1) @(posedge clk);
            #2;
            serve_request();
        end
    end

endmodule

//--- dv/rvmem_bridge_tb.sv
// testbench top for the cpu to sdram bridge
// directed and random cpu accesses, word memory model, watchdog

`timescale 1ns/1ns

`include "rvmem_config.svh"

module rvmem_bridge_tb;

    localparam int n_random  = 200;
    localparam int n_access  = n_random + 8;
    localparam int max_wait  = 40;                    // cycles per access
    localparam int wd_cycles = n_access * 40 + 200;
    localparam int word_bits = `rv_word_msb - `rv_word_lsb + 1;
    localparam logic [`rv_addr_width-1:0] base = 23'h01_2340;

    logic                         clk;
    logic                         sys_resetn;
    logic                         rv_valid;
    logic [`rv_addr_width-1:0]    rv_addr;
    logic [`rv_data_width-1:0]    rv_wdata;
    logic [`rv_strb_width-1:0]    rv_wstrb;
    logic                         rv_ready;
    logic [`rv_data_width-1:0]    rv_rdata;
    logic                         mem_req;
    logic                         mem_ack;
    logic [`mem_addr_width-1:0]   mem_addr;
    logic [`mem_data_width-1:0]   mem_din;
    logic [`mem_data_width/8-1:0] mem_ds;
    logic                         mem_we;
    logic [`mem_data_width-1:0]   mem_dout;
    int                           req_count;

    integer      seed;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_errors;
    int          ready_pulses;
    logic        req_seen;
    logic [38:0] req_log [$];                         // {we, ds, addr, din}
    logic [31:0] model [0:(1 << word_bits)-1];

    tb_clock_gen #(.period_ns(20), .reset_cycles(4)) u_clk (.clk(clk), .sys_resetn(sys_resetn));
    rvmem_bridge dut (.*);
    mem_responder #(.latency_seed(32'h8d45_f496)) u_mem (.*);

    // same pattern the responder starts from
    function automatic logic [15:0] fill_half(input logic [`mem_addr_width-1:0] a);
        return a[15:0] ^ {a[19:16], 12'h5a3};
    endfunction

    //////////////////////////////
    // bus monitors
    //////////////////////////////
    always @(negedge clk) begin
        if (rv_ready) begin
            ready_pulses++;
        end
        if (sys_resetn && (mem_req !== req_seen)) begin
            req_log.push_back({mem_we, mem_ds, mem_addr, mem_din});
            req_seen = mem_req;
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (exp === act) else begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic check_memory(input logic [`rv_addr_width-1:0] addr);
        logic [word_bits-1:0] wa;
        wa = addr[`rv_word_msb:`rv_word_lsb];
        check_value("memory lower halfword", 64'(model[wa][15:0]), 64'(u_mem.mem[{wa, 1'b0}]));
        check_value("memory upper halfword", 64'(model[wa][31:16]), 64'(u_mem.mem[{wa, 1'b1}]));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - test_errors);
            tests_failed++;
        end
        test_errors = errors;
    endtask

    //////////////////////////////
    // one cpu access
    //////////////////////////////
    task automatic do_access(input logic [`rv_addr_width-1:0] addr,
                             input logic [`rv_data_width-1:0] wdata,
                             input logic [`rv_strb_width-1:0] strb);
        logic [word_bits-1:0] wa;
        logic                 is_wr;
        logic [31:0]          rdata;
        logic [38:0]          din_mask;
        logic [38:0]          exp_q [$];
        int                   start_pulses;
        int                   start_count;
        int                   cycles;
        wa       = addr[`rv_word_msb:`rv_word_lsb];
        is_wr    = |strb;
        din_mask = is_wr ? '1 : {23'h7f_ffff, 16'h0};     // read data field is don't care
        // lower half first and write halves without strobes are skipped
        if (!is_wr || strb[1:0] != 2'b00) begin
            exp_q.push_back({is_wr, is_wr ? strb[1:0] : 2'b11, wa, 1'b0, wdata[15:0]});
        end
        if (!is_wr || strb[3:2] != 2'b00) begin
            exp_q.push_back({is_wr, is_wr ? strb[3:2] : 2'b11, wa, 1'b1, wdata[31:16]});
        end
        req_log.delete();
        start_pulses = ready_pulses;
        start_count  = req_count;
        @(posedge clk);
        #2;
        rv_valid = 1'b1;
        rv_addr  = addr;
        rv_wdata = wdata;
        rv_wstrb = strb;
        cycles   = 0;
        @(negedge clk);
        while (!rv_ready && cycles < max_wait) begin
            @(negedge clk);
            cycles++;
        end
        rdata = rv_rdata;
        check_true(rv_ready, $sformatf("no rv_ready within %0d cycles, addr %h", max_wait, addr));
        @(posedge clk);
        #2;
        rv_valid = 1'b0;
        @(posedge clk);
        #2;
        check_value("rv_ready pulses", 64'(1), 64'(ready_pulses - start_pulses));
        check_value("memory requests", 64'(exp_q.size()), 64'(req_count - start_count));
        foreach (exp_q[i]) begin
            if (i < req_log.size()) begin
                check_value("mem request {we,ds,addr,din}", 64'(exp_q[i] & din_mask),
                            64'(req_log[i] & din_mask));
            end
        end
        if (is_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model[wa][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else begin
            check_value("rv_rdata", 64'(model[wa]), 64'(rdata));
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        logic [31:0] r;
        logic [31:0] d;
        seed         = 32'h8d45_f496;
        rv_valid     = 1'b0;
        rv_addr      = '0;
        rv_wdata     = '0;
        rv_wstrb     = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        ready_pulses = 0;
        req_seen     = 1'b0;
        for (int i = 0; i < (1 << word_bits); i++) begin
            model[i] = {fill_half({i[word_bits-1:0], 1'b1}), fill_half({i[word_bits-1:0], 1'b0})};
        end
        while (sys_resetn !== 1'b1) @(posedge clk);

        repeat (20) @(posedge clk);
        #2;
        check_value("rv_ready pulses", 64'(0), 64'(ready_pulses));
        check_value("mem_req toggles", 64'(0), 64'(req_log.size()));
        check_value("mem_req", 64'(0), 64'(mem_req));
        end_test("1 idle after reset");

        do_access(base, 32'hcafe_f00d, 4'b1111);
        check_memory(base);
        end_test("2 full strobe write");

        do_access(base + 23'd4, 32'h1234_5678, 4'b1100);
        check_memory(base + 23'd4);
        do_access(base + 23'd8, 32'h9abc_def0, 4'b0011);
        check_memory(base + 23'd8);
        do_access(base + 23'd12, 32'h0bad_beef, 4'b1000);   // single byte in the upper half
        check_memory(base + 23'd12);
        do_access(base + 23'd16, 32'h5566_7788, 4'b0001);
        check_memory(base + 23'd16);
        end_test("3 half word writes");

        do_access(base, 32'h0, 4'b0000);
        do_access(base + 23'd4, 32'h0, 4'b0000);
        do_access(base + 23'd20, 32'h0, 4'b0000);           // still the fill pattern
        end_test("4 reads");

        for (int n = 0; n < n_random; n++) begin
            r = $random(seed);
            d = $random(seed);
            do_access(base + {17'd0, r[3:0], 2'b00}, d, r[8] ? 4'b0000 : r[7:4]);
        end
        end_test("5 random accesses");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- compile.f
+incdir+hw
hw/rvmem_pkg.sv
hw/bridge_req_if.sv
hw/half_done_if.sv
hw/request_capture.sv
hw/halfword_sequencer.sv
hw/read_assembler.sv
hw/rvmem_bridge.sv
dv/tb_clock_gen.sv
dv/mem_responder.sv
dv/rvmem_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module rvmem_bridge_tb -f compile.f

out=$(./obj_dir/Vrvmem_bridge_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
